//--- Bender.yml
package:
  name: dsp_test

sources:
  - source/dsp_pkg.sv
  - source/shift_unit.sv
  - source/count_unit.sv
  - source/mac_unit.sv
  - source/sum_of_products.sv
  - source/result_select.sv
  - source/dsp_test.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/dsp_test_sva.sv
      - sim/dsp_test_tb.sv

//--- dsp_test.f
source/dsp_pkg.sv
source/shift_unit.sv
source/count_unit.sv
source/mac_unit.sv
source/sum_of_products.sv
source/result_select.sv
source/dsp_test.sv
sim/tb_clock.sv
sim/dsp_test_sva.sv
sim/dsp_test_tb.sv

//--- sim/dsp_test_golden.txt
# test en sel shift_left count_up sload distance shifter_in data_a..data_h fill check
# exp_data_out_a exp_data_out_b exp_shifter_out (hex; fill=1 puts random data on data_c..data_h)
1 1 0 0 0 0 00 00000000 00001 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00002 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00003 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00004 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00005 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00006 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00007 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00008 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00009 00000 0 0 0 0 0 0 1 1 0 01 00000000
1 1 0 0 0 0 00 00000000 0000a 00000 0 0 0 0 0 0 1 1 0 02 00000000
1 1 0 0 0 0 00 00000000 0000b 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 0000c 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 0000d 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 0000e 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 0000f 00000 0 0 0 0 0 0 1 0 0 00 00000000
1 1 0 0 0 0 00 00000000 00010 00000 0 0 0 0 0 0 1 1 0 08 00000000
1 1 0 0 0 0 00 00000000 00011 00000 0 0 0 0 0 0 1 1 1 09 00000000
1 1 0 0 0 0 00 00000000 00012 00000 0 0 0 0 0 0 1 1 2 0a 00000000
2 1 1 1 0 0 04 12345678 00000 00000 0 0 0 0 0 0 1 1 0 00 23456781
2 1 1 0 0 0 08 12345678 00000 00000 0 0 0 0 0 0 1 1 23456781 00 78123456
2 1 1 1 0 0 1f 12345678 00000 00000 0 0 0 0 0 0 1 1 78123456 00 091a2b3c
2 1 1 0 0 0 10 12345678 00000 00000 0 0 0 0 0 0 1 1 091a2b3c 00 56781234
2 1 1 1 0 0 0c 12345678 00000 00000 0 0 0 0 0 0 1 1 56781234 00 45678123
3 1 2 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 0 00 00000000
3 1 2 0 1 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 0 00 00000000
3 1 2 0 1 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 1 00 00000000
3 1 2 0 1 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 2 00 00000000
3 1 2 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 3 00 00000000
3 1 2 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 2 00 00000000
3 1 2 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 1 00 00000000
3 1 2 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 0 00 00000000
3 1 3 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 10 00 00000000
3 1 3 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 30 00 00000000
4 1 4 0 0 1 00 00000000 00003 00005 0 0 0 0 0 0 1 1 0 00 00000000
4 1 4 0 0 0 00 00000000 3fffe 00007 0 0 0 0 0 0 1 1 0 00 00000000
4 1 4 0 0 0 00 00000000 00100 00100 0 0 0 0 0 0 1 1 f 00 00000000
4 1 4 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 1 00 00000000
4 1 4 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 10001 00 00000000
4 1 4 0 0 1 00 00000000 3ffff 00004 0 0 0 0 0 0 1 1 10001 00 00000000
4 1 4 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 10001 00 00000000
4 1 4 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 1 1 ffffffffffc 00 00000000
5 1 5 0 0 0 00 00000000 00002 00003 4 5 6 7 8 9 0 0 0 00 00000000
5 1 5 0 0 0 00 00000000 3ffff 00064 3fffd 3fffb 1ffff 2 0 0 0 0 0 00 00000000
5 1 5 0 0 0 00 00000000 20000 20000 20000 1ffff 3fff9 9 0 0 0 0 0 00 00000000
5 1 5 0 0 0 00 00000000 3fff6 0000a 0 0 0 0 0 0 0 1 8c 00 00000000
5 1 5 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 0 1 3ffa9 00 00000000
5 1 5 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 0 1 1ffc1 00 00000000
5 1 5 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 0 1 fffffffff9c 00 00000000
6 0 0 1 1 1 03 ffffffff 000ff 00007 0 0 0 0 0 0 0 1 fffffffff9c 00 00000000
6 0 6 1 1 1 03 ffffffff 000ff 00007 0 0 0 0 0 0 0 1 fffffffff9c 00 00000000
6 0 1 1 1 1 03 ffffffff 000ff 00007 0 0 0 0 0 0 0 1 fffffffff9c 00 00000000
6 1 6 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 0 1 0 00 00000000
6 1 7 0 0 0 00 00000000 00000 00000 0 0 0 0 0 0 0 1 0 00 00000000

//--- sim/dsp_test_sva.sv
`default_nettype none

module dsp_test_sva #(
	parameter int SHIFT_W = 32
) (
	input wire logic                         clk_1,
	input wire logic                         rst_n,
	input wire logic                         enable,
	input wire dsp_pkg::dsp_sel_e            sel,
	input wire logic [SHIFT_W-1:0]           shifter_out,
	input wire logic [dsp_pkg::RESULT_W-1:0] data_out_a,
	input wire logic [dsp_pkg::BYTE_W-1:0]   data_out_b
);

	int failures = 0;

	reset_clears: assert property (@(posedge clk_1)
		!rst_n |=> (data_out_a == '0 && data_out_b == '0 && shifter_out == '0))
		else begin
			$error("outputs not zero after reset");
			failures++;
		end

	tap_only_for_delay: assert property (@(posedge clk_1)
		(rst_n && enable && sel != dsp_pkg::SEL_DELAY) |=> data_out_b == '0)
		else begin
			$error("data_out_b nonzero without delay select");
			failures++;
		end

	// Frozen state while the clock enable is low
	hold_when_disabled: assert property (@(posedge clk_1)
		(rst_n && !enable) |=>
		($stable(data_out_a) && $stable(data_out_b) && $stable(shifter_out)))
		else begin
			$error("outputs changed with enable low");
			failures++;
		end

endmodule

bind dsp_test dsp_test_sva #(.SHIFT_W(SHIFT_W)) dsp_test_sva_inst (
	.clk_1       (clk_1),
	.rst_n       (rst_n),
	.enable      (enable),
	.sel         (sel),
	.shifter_out (shifter_out),
	.data_out_a  (data_out_a),
	.data_out_b  (data_out_b)
);

`default_nettype wire

//--- sim/dsp_test_tb.sv
`default_nettype none

module dsp_test_tb;

	localparam int PERIOD = 100;
	localparam int MAX_LINES = 128;
	localparam int NUM_COLS = 21;
	localparam int RESET_CYCLES = 16;

	logic                         clk_1;
	logic                         rst_n;
	logic                         enable;
	logic                         shift_left;
	logic                         count_up;
	logic                         sload;
	logic [4:0]                   distance;
	dsp_pkg::dsp_sel_e            sel;
	logic [dsp_pkg::DATA_W-1:0]   data_a;
	logic [dsp_pkg::DATA_W-1:0]   data_b;
	logic [dsp_pkg::DATA_W-1:0]   data_c;
	logic [dsp_pkg::DATA_W-1:0]   data_d;
	logic [dsp_pkg::DATA_W-1:0]   data_e;
	logic [dsp_pkg::DATA_W-1:0]   data_f;
	logic [dsp_pkg::DATA_W-1:0]   data_g;
	logic [dsp_pkg::DATA_W-1:0]   data_h;
	logic [31:0]                  shifter_in;
	logic [31:0]                  shifter_out;
	logic [dsp_pkg::RESULT_W-1:0] data_out_a;
	logic [dsp_pkg::BYTE_W-1:0]   data_out_b;

	logic [63:0] vec [MAX_LINES][NUM_COLS]; // One row per clock cycle
	int num_lines = 0;
	bit loaded = 1'b0;
	int seed = 32'he399_6435;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_failed = 0;

	tb_clock #(.PERIOD(PERIOD)) tb_clock_inst (.clk(clk_1));

	dsp_test dsp_test_inst (
		.clk_1 (clk_1), .rst_n (rst_n), .enable (enable),
		.shift_left (shift_left), .count_up (count_up), .sload (sload),
		.distance (distance), .sel (sel),
		.data_a (data_a), .data_b (data_b), .data_c (data_c), .data_d (data_d),
		.data_e (data_e), .data_f (data_f), .data_g (data_g), .data_h (data_h),
		.shifter_in (shifter_in), .shifter_out (shifter_out),
		.data_out_a (data_out_a), .data_out_b (data_out_b)
	);

	function automatic logic [dsp_pkg::DATA_W-1:0] random_operand();
		int r;
		r = $random(seed);
		return r[dsp_pkg::DATA_W-1:0];
	endfunction

	task automatic read_vectors();
		int fd;
		int n;
		string line;
		logic [63:0] f [NUM_COLS];
		fd = $fopen("sim/dsp_test_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden vector file");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin // Skip comments
				n = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
					f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
				if (n == NUM_COLS && num_lines < MAX_LINES) begin
					vec[num_lines] = f;
					num_lines++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_vector(input int i);
		enable     = vec[i][1][0];
		sel        = dsp_pkg::dsp_sel_e'(vec[i][2][2:0]);
		shift_left = vec[i][3][0];
		count_up   = vec[i][4][0];
		sload      = vec[i][5][0];
		distance   = vec[i][6][4:0];
		shifter_in = vec[i][7][31:0];
		data_a     = vec[i][8][dsp_pkg::DATA_W-1:0];
		data_b     = vec[i][9][dsp_pkg::DATA_W-1:0];
		if (vec[i][16][0]) begin // Filler, no effect on checked results
			data_c = random_operand();
			data_d = random_operand();
			data_e = random_operand();
			data_f = random_operand();
			data_g = random_operand();
			data_h = random_operand();
		end else begin
			data_c = vec[i][10][dsp_pkg::DATA_W-1:0];
			data_d = vec[i][11][dsp_pkg::DATA_W-1:0];
			data_e = vec[i][12][dsp_pkg::DATA_W-1:0];
			data_f = vec[i][13][dsp_pkg::DATA_W-1:0];
			data_g = vec[i][14][dsp_pkg::DATA_W-1:0];
			data_h = vec[i][15][dsp_pkg::DATA_W-1:0];
		end
	endtask

	task automatic check_outputs(input int i);
		test_checks++;
		assert (data_out_a === vec[i][18][dsp_pkg::RESULT_W-1:0]) else begin
			$display("ERR data_out_a row %0d: expected %h, got %h",
				i + 1, vec[i][18][43:0], data_out_a);
			test_errors++;
		end
		assert (data_out_b === vec[i][19][dsp_pkg::BYTE_W-1:0]) else begin
			$display("ERR data_out_b row %0d: expected %h, got %h",
				i + 1, vec[i][19][7:0], data_out_b);
			test_errors++;
		end
		assert (shifter_out === vec[i][20][31:0]) else begin
			$display("ERR shifter_out row %0d: expected %h, got %h",
				i + 1, vec[i][20][31:0], shifter_out);
			test_errors++;
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s: %0d checks, %0d errors", t, (test_errors == 0) ? "ok" : "failed",
			test_checks, test_errors);
		if (test_errors != 0) tests_failed++;
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		rst_n = 1'b0;
		enable = 1'b0;
		shift_left = 1'b0;
		count_up = 1'b0;
		sload = 1'b0;
		distance = '0;
		sel = dsp_pkg::SEL_DELAY;
		shifter_in = '0;
		data_a = '0;
		data_b = '0;
		data_c = '0;
		data_d = '0;
		data_e = '0;
		data_f = '0;
		data_g = '0;
		data_h = '0;
		read_vectors();
		if (num_lines == 0) begin
			$display("no test vectors were read");
			total_errors++;
		end
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_1);
		rst_n = 1'b1;
		for (int i = 0; i < num_lines; i++) begin
			apply_vector(i);
			@(negedge clk_1); // Result of the rising edge in between
			if (vec[i][17][0]) check_outputs(i);
			if (i == num_lines - 1 || vec[i+1][0] != vec[i][0]) report_test(vec[i][0]);
		end
		total_errors += dsp_test_inst.dsp_test_sva_inst.failures;
		$display("tests failed %0d, checks %0d, errors %0d", tests_failed, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#((num_lines + RESET_CYCLES + 20) * PERIOD);
		$display("timeout: the vectors did not finish in the expected time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD/2) clk = ~clk; // Rising edge at half period

endmodule

`default_nettype wire

//--- source/count_unit.sv
`default_nettype none

module count_unit #(
	parameter int COUNT_W = 16
) (
	input  logic               clk_1,
	input  logic               rst_n,
	input  logic               enable,
	input  logic               count_up,
	output logic [COUNT_W-1:0] count,
	output logic [COUNT_W-1:0] gray_count
);

	localparam logic [COUNT_W-1:0] COUNT_MAX = '1;

	logic [COUNT_W-1:0] gray_bin;
	logic [COUNT_W-1:0] gray_bin_next;

	assign gray_bin_next = gray_bin + COUNT_W'(1);

	// Up/down counter, sticks at either end
	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			count <= '0;
		end else if (enable) begin
			if (count_up && count != COUNT_MAX) begin
				count <= count + COUNT_W'(1);
			end else if (!count_up && count != '0) begin
				count <= count - COUNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			gray_bin   <= '0;
			gray_count <= '0;
		end else if (enable) begin
			gray_bin   <= gray_bin_next;
			gray_count <= gray_bin_next ^ (gray_bin_next >> 1); // Tracks gray_bin
		end
	end

endmodule

`default_nettype wire

//--- source/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	// Multiplier operand width
	localparam int DATA_W = 18;

	// Wide result port
	localparam int RESULT_W = 44;

	// Delay line data and tap port
	localparam int BYTE_W = 8;

	// Result choice at the output selector
	typedef enum logic [2:0] {
		SEL_DELAY  = 3'd0,
		SEL_BARREL = 3'd1,
		SEL_COUNT  = 3'd2,
		SEL_GRAY   = 3'd3,
		SEL_MAC    = 3'd4,
		SEL_SOP    = 3'd5
	} dsp_sel_e; // Codes 6 and 7 select zero

endpackage

`default_nettype wire

//--- source/dsp_test.sv
`default_nettype none

module dsp_test #(
	parameter int DELAY_DEPTH = 16,
	parameter int COUNT_W = 16,
	parameter int SHIFT_W = 32
) (
	input  logic                         clk_1,
	input  logic                         rst_n,
	input  logic                         enable,
	input  logic                         shift_left,
	input  logic                         count_up,
	input  logic                         sload,
	input  logic [4:0]                   distance,
	input  dsp_pkg::dsp_sel_e            sel,
	input  logic [dsp_pkg::DATA_W-1:0]   data_a,
	input  logic [dsp_pkg::DATA_W-1:0]   data_b,
	input  logic [dsp_pkg::DATA_W-1:0]   data_c,
	input  logic [dsp_pkg::DATA_W-1:0]   data_d,
	input  logic [dsp_pkg::DATA_W-1:0]   data_e,
	input  logic [dsp_pkg::DATA_W-1:0]   data_f,
	input  logic [dsp_pkg::DATA_W-1:0]   data_g,
	input  logic [dsp_pkg::DATA_W-1:0]   data_h,
	input  logic [SHIFT_W-1:0]           shifter_in,
	output logic [SHIFT_W-1:0]           shifter_out,
	output logic [dsp_pkg::RESULT_W-1:0] data_out_a,
	output logic [dsp_pkg::BYTE_W-1:0]   data_out_b
);

	logic [dsp_pkg::BYTE_W-1:0]          delay_out;
	logic [dsp_pkg::BYTE_W-1:0]          delay_tap;
	logic [COUNT_W-1:0]                  count;
	logic [COUNT_W-1:0]                  gray_count;
	logic signed [dsp_pkg::RESULT_W-1:0] mac_out;
	logic signed [dsp_pkg::RESULT_W-1:0] sop_out;

	shift_unit #(
		.DELAY_DEPTH (DELAY_DEPTH),
		.SHIFT_W     (SHIFT_W)
	) shift_unit_inst (
		.clk_1       (clk_1),
		.rst_n       (rst_n),
		.enable      (enable),
		.shift_left  (shift_left),
		.distance    (distance),
		.delay_in    (data_a[dsp_pkg::BYTE_W-1:0]), // Low byte only
		.shifter_in  (shifter_in),
		.delay_out   (delay_out),
		.delay_tap   (delay_tap),
		.shifter_out (shifter_out)
	);

	count_unit #(
		.COUNT_W (COUNT_W)
	) count_unit_inst (
		.clk_1      (clk_1),
		.rst_n      (rst_n),
		.enable     (enable),
		.count_up   (count_up),
		.count      (count),
		.gray_count (gray_count)
	);

	mac_unit mac_unit_inst (
		.clk_1   (clk_1),
		.rst_n   (rst_n),
		.enable  (enable),
		.sload   (sload),
		.mul_a   (data_a),
		.mul_b   (data_b),
		.mac_out (mac_out)
	);

	sum_of_products sum_of_products_inst (
		.clk_1   (clk_1),
		.rst_n   (rst_n),
		.enable  (enable),
		.data_a  (data_a),
		.data_b  (data_b),
		.data_c  (data_c),
		.data_d  (data_d),
		.data_e  (data_e),
		.data_f  (data_f),
		.data_g  (data_g),
		.data_h  (data_h),
		.sop_out (sop_out)
	);

	result_select #(
		.COUNT_W (COUNT_W),
		.SHIFT_W (SHIFT_W)
	) result_select_inst (
		.clk_1       (clk_1),
		.rst_n       (rst_n),
		.enable      (enable),
		.sel         (sel),
		.delay_out   (delay_out),
		.delay_tap   (delay_tap),
		.shifter_out (shifter_out), // Already registered once
		.count       (count),
		.gray_count  (gray_count),
		.mac_out     (mac_out),
		.sop_out     (sop_out),
		.data_out_a  (data_out_a),
		.data_out_b  (data_out_b)
	);

endmodule

`default_nettype wire

//--- source/mac_unit.sv
`default_nettype none

module mac_unit (
	input  logic                                clk_1,
	input  logic                                rst_n,
	input  logic                                enable,
	input  logic                                sload,
	input  logic signed [dsp_pkg::DATA_W-1:0]   mul_a,
	input  logic signed [dsp_pkg::DATA_W-1:0]   mul_b,
	output logic signed [dsp_pkg::RESULT_W-1:0] mac_out
);

	localparam int PROD_W = 2 * dsp_pkg::DATA_W;
	localparam int EXT_W  = dsp_pkg::RESULT_W - PROD_W;

	logic signed [dsp_pkg::DATA_W-1:0]   a_q;
	logic signed [dsp_pkg::DATA_W-1:0]   b_q;
	logic                                sload_q;
	logic signed [PROD_W-1:0]            product;
	logic signed [dsp_pkg::RESULT_W-1:0] product_ext;

	assign product     = a_q * b_q;
	assign product_ext = {{EXT_W{product[PROD_W-1]}}, product};

	// Operand stage
	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			a_q     <= '0;
			b_q     <= '0;
			sload_q <= 1'b0;
		end else if (enable) begin
			a_q     <= mul_a;
			b_q     <= mul_b;
			sload_q <= sload; // Follows its operands
		end
	end

	// Accumulator, wraps on overflow
	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			mac_out <= '0;
		end else if (enable) begin
			if (sload_q) begin
				mac_out <= product_ext;
			end else begin
				mac_out <= mac_out + product_ext;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/result_select.sv
`default_nettype none

module result_select #(
	parameter int COUNT_W = 16,
	parameter int SHIFT_W = 32
) (
	input  logic                                clk_1,
	input  logic                                rst_n,
	input  logic                                enable,
	input  dsp_pkg::dsp_sel_e                   sel,
	input  logic [dsp_pkg::BYTE_W-1:0]          delay_out,
	input  logic [dsp_pkg::BYTE_W-1:0]          delay_tap,
	input  logic [SHIFT_W-1:0]                  shifter_out,
	input  logic [COUNT_W-1:0]                  count,
	input  logic [COUNT_W-1:0]                  gray_count,
	input  logic signed [dsp_pkg::RESULT_W-1:0] mac_out,
	input  logic signed [dsp_pkg::RESULT_W-1:0] sop_out,
	output logic [dsp_pkg::RESULT_W-1:0]        data_out_a,
	output logic [dsp_pkg::BYTE_W-1:0]          data_out_b
);

	localparam int BYTE_PAD  = dsp_pkg::RESULT_W - dsp_pkg::BYTE_W;
	localparam int SHIFT_PAD = dsp_pkg::RESULT_W - SHIFT_W;
	localparam int COUNT_PAD = dsp_pkg::RESULT_W - COUNT_W;

	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			data_out_a <= '0;
			data_out_b <= '0;
		end else if (enable) begin
			data_out_b <= '0; // Tap only for SEL_DELAY
			case (sel)
				dsp_pkg::SEL_DELAY: begin
					data_out_a <= {{BYTE_PAD{1'b0}}, delay_out};
					data_out_b <= delay_tap;
				end
				dsp_pkg::SEL_BARREL: data_out_a <= {{SHIFT_PAD{1'b0}}, shifter_out};
				dsp_pkg::SEL_COUNT:  data_out_a <= {{COUNT_PAD{1'b0}}, count};
				dsp_pkg::SEL_GRAY:   data_out_a <= {{COUNT_PAD{1'b0}}, gray_count};
				dsp_pkg::SEL_MAC:    data_out_a <= mac_out;
				dsp_pkg::SEL_SOP:    data_out_a <= sop_out;
				default:             data_out_a <= '0; // Unused codes
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/shift_unit.sv
`default_nettype none

module shift_unit #(
	parameter int DELAY_DEPTH = 16,
	parameter int SHIFT_W = 32
) (
	input  logic                        clk_1,
	input  logic                        rst_n,
	input  logic                        enable,
	input  logic                        shift_left,
	input  logic [4:0]                  distance,
	input  logic [dsp_pkg::BYTE_W-1:0]  delay_in,
	input  logic [SHIFT_W-1:0]          shifter_in,
	output logic [dsp_pkg::BYTE_W-1:0]  delay_out,
	output logic [dsp_pkg::BYTE_W-1:0]  delay_tap,
	output logic [SHIFT_W-1:0]          shifter_out
);

	logic [dsp_pkg::BYTE_W-1:0] taps [DELAY_DEPTH];
	logic [2*SHIFT_W-1:0]       doubled;
	logic [2*SHIFT_W-1:0]       rot_left;
	logic [2*SHIFT_W-1:0]       rot_right;

	// Input placed twice so a plain shift wraps around
	assign doubled   = {shifter_in, shifter_in};
	assign rot_left  = doubled << distance;
	assign rot_right = doubled >> distance;

	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			for (int i = 0; i < DELAY_DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else if (enable) begin
			taps[0] <= delay_in;
			for (int i = 1; i < DELAY_DEPTH; i++) begin
				taps[i] <= taps[i-1]; // Byte moves one stage per edge
			end
		end
	end

	assign delay_out = taps[DELAY_DEPTH-1];
	assign delay_tap = taps[DELAY_DEPTH/2-1]; // Middle stage

	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			shifter_out <= '0;
		end else if (enable) begin
			if (shift_left) begin
				shifter_out <= rot_left[2*SHIFT_W-1 -: SHIFT_W]; // Upper half
			end else begin
				shifter_out <= rot_right[SHIFT_W-1:0]; // Lower half
			end
		end
	end

endmodule

`default_nettype wire

//--- source/sum_of_products.sv
`default_nettype none

module sum_of_products (
	input  logic                                clk_1,
	input  logic                                rst_n,
	input  logic                                enable,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_a,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_b,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_c,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_d,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_e,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_f,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_g,
	input  logic signed [dsp_pkg::DATA_W-1:0]   data_h,
	output logic signed [dsp_pkg::RESULT_W-1:0] sop_out
);

	localparam int PROD_W = 2 * dsp_pkg::DATA_W;
	localparam int PAIR_W = PROD_W + 1;
	localparam int EXT_W  = dsp_pkg::RESULT_W - PAIR_W;

	logic signed [PROD_W-1:0] prod_ab;
	logic signed [PROD_W-1:0] prod_cd;
	logic signed [PROD_W-1:0] prod_ef;
	logic signed [PROD_W-1:0] prod_gh;
	logic signed [PAIR_W-1:0] pair_0;
	logic signed [PAIR_W-1:0] pair_1;

	always_ff @(posedge clk_1) begin
		if (!rst_n) begin
			prod_ab <= '0;
			prod_cd <= '0;
			prod_ef <= '0;
			prod_gh <= '0;
			pair_0  <= '0;
			pair_1  <= '0;
			sop_out <= '0;
		end else if (enable) begin
			prod_ab <= data_a * data_b; // Stage 1
			prod_cd <= data_c * data_d;
			prod_ef <= data_e * data_f;
			prod_gh <= data_g * data_h;
			// Stage 2, one extra bit per pair
			pair_0 <= {prod_ab[PROD_W-1], prod_ab} + {prod_cd[PROD_W-1], prod_cd};
			pair_1 <= {prod_ef[PROD_W-1], prod_ef} + {prod_gh[PROD_W-1], prod_gh};
			sop_out <= {{EXT_W{pair_0[PAIR_W-1]}}, pair_0}
				+ {{EXT_W{pair_1[PAIR_W-1]}}, pair_1}; // Stage 3
		end
	end

endmodule

`default_nettype wire
